// File: hw/ctrl_pkg.sv
/*
  shared definitions of the machine-mode trap and flow controller
  widths, fetch selectors, trap causes and the records between blocks
*/
package ctrl_pkg;

  // default number of fast interrupt lines
  localparam int unsigned NUM_FAST_IRQ_DEF = 15;

  // data and address word
  typedef logic [31:0] xlen_t;
  // compressed instruction halfword
  typedef logic [15:0] cinsn_t;
  // fast interrupt id
  typedef logic [3:0]  fast_id_t;

  // fetch address selector
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_MRET
  } pc_sel_e;

  // trap cause, bit 5 marks an interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 5'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_LOAD_ACCESS_FAULT  = {1'b0, 5'd5},
    EXC_CAUSE_STORE_ACCESS_FAULT = {1'b0, 5'd7},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11},
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    // fast interrupts occupy 16 + id
    EXC_CAUSE_IRQ_FAST_0         = {1'b1, 5'd16},
    EXC_CAUSE_IRQ_FAST_14        = {1'b1, 5'd30},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_cause_e;

  // instruction held in the decode stage
  typedef struct packed {
    xlen_t  instr;
    cinsn_t instr_c;
    logic   is_comp;
    logic   fetch_err;
    xlen_t  pc;
  } id_instr_t;

  // raw decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebreak;
    logic csr_flush;
  } dec_flags_t;

  // interrupt inputs from the CSR file and the pins
  typedef struct packed {
    logic                        mie;
    logic                        pending;
    logic                        nm;
    logic                        meip;
    logic                        msip;
    logic                        mtip;
    logic [NUM_FAST_IRQ_DEF-1:0] mfip;
  } irq_in_t;

  // one recorded trap or special request
  typedef struct packed {
    logic       exc;
    exc_cause_e cause;
    xlen_t      mtval;
    logic       mret;
    logic       wfi;
    logic       csr_flush;
  } trap_rec_t;

  // interrupt decision
  typedef struct packed {
    logic       take;
    exc_cause_e cause;
    logic       fast_ack;
    fast_id_t   fast_id;
  } irq_dec_t;

  // controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

endpackage

// File: hw/trap_recorder.sv
/*
  trap recorder
  qualifies decoder flags, ranks exception causes and keeps a one-deep
  record of the request raised by the instruction in decode
*/
`timescale 1ns/10ps

module trap_recorder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  ctrl_pkg::id_instr_t  instr_i,
  input  ctrl_pkg::dec_flags_t flags_i,
  input  logic                 load_err_i,
  input  logic                 store_err_i,
  input  ctrl_pkg::xlen_t      lsu_addr_i,
  input  logic                 in_decode_i,
  input  logic                 in_flush_i,
  output logic                 special_o,
  output ctrl_pkg::trap_rec_t  rec_o
);
  import ctrl_pkg::*;

  trap_rec_t  rec_d;
  trap_rec_t  rec_q;

  //////////////////////////////
  // cause ranking
  //////////////////////////////

  always_comb begin
    rec_d = '0;
    // decoder ignores instruction valid, fold it in here
    if (in_decode_i && valid_i) begin
      if (instr_i.fetch_err) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
        rec_d.mtval = instr_i.pc;
      end else if (flags_i.illegal) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_ILLEGAL_INSN;
        // compressed encodings report only their halfword
        rec_d.mtval = instr_i.is_comp ? {16'b0, instr_i.instr_c} : instr_i.instr;
      end else if (flags_i.ecall) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_ECALL_MMODE;
      end else if (flags_i.ebreak) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_BREAKPOINT;
      end else if (store_err_i) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
        rec_d.mtval = lsu_addr_i;
      end else if (load_err_i) begin
        rec_d.exc   = 1'b1;
        rec_d.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
        rec_d.mtval = lsu_addr_i;
      end else if (flags_i.mret) begin
        rec_d.mret = 1'b1;
      end else if (flags_i.wfi) begin
        rec_d.wfi = 1'b1;
      end else if (flags_i.csr_flush) begin
        rec_d.csr_flush = 1'b1;
      end
    end
  end

  // same-cycle request so the FSM can leave decode
  assign special_o = rec_d.exc | rec_d.mret | rec_d.wfi | rec_d.csr_flush;

  // only decode cycles produce a record, flush wipes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_q <= '0;
    end else if (in_flush_i) begin
      rec_q <= '0;
    end else if (in_decode_i) begin
      rec_q <= rec_d;
    end
  end

  assign rec_o = rec_q;

  // an exception and the special kinds never share a record
  a_rec_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rec_q.exc, rec_q.mret, rec_q.wfi, rec_q.csr_flush}));

endmodule

// File: hw/irq_arbiter.sv
/*
  interrupt arbiter
  tracks NMI mode, decides on taking an interrupt and picks its cause
*/
`timescale 1ns/10ps

module irq_arbiter #(
  parameter int unsigned NUM_FAST_IRQ = ctrl_pkg::NUM_FAST_IRQ_DEF
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ctrl_pkg::irq_in_t  irq_i,
  input  logic               irq_taken_i,
  input  logic               mret_done_i,
  output logic               nmi_mode_o,
  output ctrl_pkg::irq_dec_t dec_o
);
  import ctrl_pkg::*;

  logic                    nmi_mode_q;
  logic                    nmi_take;
  logic [NUM_FAST_IRQ-1:0] mfip;
  fast_id_t                fast_id;

  // only the implemented fast lines take part
  assign mfip     = irq_i.mfip[NUM_FAST_IRQ-1:0];
  assign nmi_take = irq_i.nm & ~nmi_mode_q;

  // highest pending id wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int unsigned i = 0; i < NUM_FAST_IRQ; i++) begin
      if (mfip[i]) begin
        fast_id = fast_id_t'(i);
      end
    end
  end

  //////////////////////////////
  // decision and cause
  //////////////////////////////

  always_comb begin
    dec_o          = '0;
    dec_o.take     = nmi_take | (irq_i.pending & irq_i.mie);
    dec_o.fast_id  = fast_id;
    if (nmi_take) begin
      dec_o.cause = EXC_CAUSE_IRQ_NM;
    end else if (|mfip) begin
      // interrupt bit plus 16 plus the id
      dec_o.cause    = exc_cause_e'({2'b11, fast_id});
      dec_o.fast_ack = dec_o.take;
    end else if (irq_i.meip) begin
      dec_o.cause = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_i.msip) begin
      dec_o.cause = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      dec_o.cause = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // NMI mode blocks nested NMIs until MRET
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (mret_done_i) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_taken_i && dec_o.cause == EXC_CAUSE_IRQ_NM) begin
      nmi_mode_q <= 1'b1;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

  // acknowledged id is pending and no higher fast line is
  a_ack_take : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_o.fast_ack |-> dec_o.take && ((mfip >> dec_o.fast_id) == 1));

endmodule

// File: hw/ctrl_fsm.sv
/*
  control state machine
  sequences boot, decode, flush, sleep and interrupt entry and drives
  the fetch redirect, CSR strobes and decode handshake
*/
`timescale 1ns/10ps

module ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 stall_i,
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,
  input  logic                 irq_wake_i,
  input  logic                 special_i,
  input  ctrl_pkg::trap_rec_t  rec_i,
  input  ctrl_pkg::irq_dec_t   irq_dec_i,
  output logic                 in_decode_o,
  output logic                 in_flush_o,
  output logic                 irq_taken_o,
  output logic                 mret_done_o,
  output logic                 busy_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_sel_e    pc_sel_o,
  output ctrl_pkg::exc_cause_e exc_cause_o,
  output ctrl_pkg::xlen_t      csr_mtval_o,
  output logic                 csr_save_pc_o,
  output logic                 csr_save_cause_o,
  output logic                 csr_restore_mret_o,
  output logic                 irq_ack_o,
  output ctrl_pkg::fast_id_t   irq_ack_id_o,
  output logic                 id_ready_o,
  output logic                 instr_clear_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // halt keeps the instruction in decode, flush drops it
  logic        halt_if;
  logic        flush_id;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d            = state_q;
    instr_req_o        = 1'b1;
    busy_o             = 1'b1;
    pc_set_o           = 1'b0;
    pc_sel_o           = PC_BOOT;
    exc_cause_o        = EXC_CAUSE_INSN_ADDR_MISA;
    csr_mtval_o        = '0;
    csr_save_pc_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    irq_ack_o          = 1'b0;
    irq_ack_id_o       = '0;
    irq_taken_o        = 1'b0;
    mret_done_o        = 1'b0;
    halt_if            = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        halt_if     = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        halt_if  = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // any pending line wakes, even when globally disabled
        if (irq_wake_i) begin
          state_d = FIRST_FETCH;
        end
      end
      FIRST_FETCH: begin
        if (!stall_i) begin
          state_d = DECODE;
        end
        // pipeline is empty here, so take the interrupt at once
        if (irq_dec_i.take) begin
          state_d  = IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      DECODE: begin
        if (instr_valid_i) begin
          if (special_i) begin
            // keep the instruction, the flush cycle decides
            state_d = FLUSH;
            halt_if = 1'b1;
          end else if (branch_set_i || jump_set_i) begin
            pc_sel_o = PC_JUMP;
            pc_set_o = 1'b1;
          end
        end
        // a multicycle instruction finishes before the interrupt
        if (!stall_i && !special_i && irq_dec_i.take) begin
          state_d  = IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (rec_i.exc) begin
          pc_set_o         = 1'b1;
          pc_sel_o         = PC_EXC;
          csr_save_pc_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = rec_i.cause;
          csr_mtval_o      = rec_i.mtval;
        end else if (rec_i.mret) begin
          pc_set_o           = 1'b1;
          pc_sel_o           = PC_MRET;
          csr_restore_mret_o = 1'b1;
          mret_done_o        = 1'b1;
        end else if (rec_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (rec_i.csr_flush && irq_dec_i.take) begin
          // a CSR write may have just enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end
      IRQ_TAKEN: begin
        if (irq_dec_i.take) begin
          pc_set_o         = 1'b1;
          pc_sel_o         = PC_EXC;
          csr_save_pc_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq_dec_i.cause;
          irq_ack_o        = irq_dec_i.fast_ack;
          irq_ack_id_o     = irq_dec_i.fast_ack ? irq_dec_i.fast_id : '0;
          irq_taken_o      = 1'b1;
        end
        state_d = DECODE;
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  assign in_decode_o = (state_q == DECODE);
  assign in_flush_o  = (state_q == FLUSH);

  // decode handshake
  assign id_ready_o    = ~stall_i & ~halt_if;
  assign instr_clear_o = ~(stall_i | halt_if) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  a_state_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

endmodule

// File: hw/core_ctrl.sv
/*
  machine-mode trap and flow controller
  trap recorder and interrupt arbiter feed the control state machine
*/
`timescale 1ns/10ps

module core_ctrl #(
  parameter int unsigned NUM_FAST_IRQ = ctrl_pkg::NUM_FAST_IRQ_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  ctrl_pkg::id_instr_t  instr_i,
  input  ctrl_pkg::dec_flags_t flags_i,
  input  logic                 load_err_i,
  input  logic                 store_err_i,
  input  ctrl_pkg::xlen_t      lsu_addr_i,
  input  logic                 stall_i,
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,
  input  ctrl_pkg::irq_in_t    irq_i,
  output logic                 nmi_mode_o,
  output logic                 busy_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_sel_e    pc_sel_o,
  output ctrl_pkg::exc_cause_e exc_cause_o,
  output ctrl_pkg::xlen_t      csr_mtval_o,
  output logic                 csr_save_pc_o,
  output logic                 csr_save_cause_o,
  output logic                 csr_restore_mret_o,
  output logic                 irq_ack_o,
  output ctrl_pkg::fast_id_t   irq_ack_id_o,
  output logic                 id_ready_o,
  output logic                 instr_clear_o
);
  import ctrl_pkg::*;

  trap_rec_t rec;
  irq_dec_t  irq_dec;
  logic      special;
  logic      in_decode;
  logic      in_flush;
  logic      irq_taken;
  logic      mret_done;
  logic      irq_wake;

  // sleep ends on any pending line or an NMI
  assign irq_wake = irq_i.pending | irq_i.nm;

  trap_recorder u_trap_recorder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (instr_valid_i),
    .instr_i     (instr_i),
    .flags_i     (flags_i),
    .load_err_i  (load_err_i),
    .store_err_i (store_err_i),
    .lsu_addr_i  (lsu_addr_i),
    .in_decode_i (in_decode),
    .in_flush_i  (in_flush),
    .special_o   (special),
    .rec_o       (rec)
  );

  irq_arbiter #(
    .NUM_FAST_IRQ (NUM_FAST_IRQ)
  ) u_irq_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_i       (irq_i),
    .irq_taken_i (irq_taken),
    .mret_done_i (mret_done),
    .nmi_mode_o  (nmi_mode_o),
    .dec_o       (irq_dec)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .stall_i            (stall_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .irq_wake_i         (irq_wake),
    .special_i          (special),
    .rec_i              (rec),
    .irq_dec_i          (irq_dec),
    .in_decode_o        (in_decode),
    .in_flush_o         (in_flush),
    .irq_taken_o        (irq_taken),
    .mret_done_o        (mret_done),
    .busy_o             (busy_o),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_sel_o           (pc_sel_o),
    .exc_cause_o        (exc_cause_o),
    .csr_mtval_o        (csr_mtval_o),
    .csr_save_pc_o      (csr_save_pc_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .irq_ack_o          (irq_ack_o),
    .irq_ack_id_o       (irq_ack_id_o),
    .id_ready_o         (id_ready_o),
    .instr_clear_o      (instr_clear_o)
  );

endmodule

// File: sim/tb_core_ctrl.sv
/*
  testbench for the machine-mode trap and flow controller
  boots the DUT, then walks a table of traps, interrupts, MRET, WFI and stalls
*/
`timescale 1ns/10ps

module tb_core_ctrl;
  import ctrl_pkg::*;

  localparam int unsigned TIMEOUT  = 50;
  localparam int unsigned WINDOW   = 6;
  localparam logic [5:0]  IRQ_FLAG = 6'd32;
  localparam irq_in_t     NO_IRQ   = '0;

  // how a row is applied
  typedef enum logic [2:0] {
    ROW_SYNC,
    ROW_IRQ,
    ROW_BLOCK,
    ROW_WFI,
    ROW_STALL
  } kind_e;

  // where the expected mtval comes from
  typedef enum logic [2:0] {
    MT_ZERO,
    MT_PC,
    MT_WORD,
    MT_HALF,
    MT_ADDR
  } mtval_e;

  typedef struct packed {
    kind_e      kind;
    dec_flags_t flags;
    // is_comp, fetch_err, load_err, store_err
    logic [3:0] errs;
    irq_in_t    irq;
    pc_sel_e    sel;
    logic [5:0] cause;
    mtval_e     mtval;
    // ack flag and fast id
    logic [4:0] ack;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic        instr_valid_i;
  id_instr_t   instr_i;
  dec_flags_t  flags_i;
  logic        load_err_i;
  logic        store_err_i;
  xlen_t       lsu_addr_i;
  logic        stall_i;
  logic        branch_set_i;
  logic        jump_set_i;
  irq_in_t     irq_i;
  logic        nmi_mode_o;
  logic        busy_o;
  logic        instr_req_o;
  logic        pc_set_o;
  pc_sel_e     pc_sel_o;
  exc_cause_e  exc_cause_o;
  xlen_t       csr_mtval_o;
  logic        csr_save_pc_o;
  logic        csr_save_cause_o;
  logic        csr_restore_mret_o;
  logic        irq_ack_o;
  fast_id_t    irq_ack_id_o;
  logic        id_ready_o;
  logic        instr_clear_o;

  row_t        rows[$];
  string       names[$];
  string       cur_test;
  logic [31:0] rng_state;

  core_ctrl #(
    .NUM_FAST_IRQ (NUM_FAST_IRQ_DEF)
  ) dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .instr_i            (instr_i),
    .flags_i            (flags_i),
    .load_err_i         (load_err_i),
    .store_err_i        (store_err_i),
    .lsu_addr_i         (lsu_addr_i),
    .stall_i            (stall_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .irq_i              (irq_i),
    .nmi_mode_o         (nmi_mode_o),
    .busy_o             (busy_o),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_sel_o           (pc_sel_o),
    .exc_cause_o        (exc_cause_o),
    .csr_mtval_o        (csr_mtval_o),
    .csr_save_pc_o      (csr_save_pc_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .irq_ack_o          (irq_ack_o),
    .irq_ack_id_o       (irq_ack_id_o),
    .id_ready_o         (id_ready_o),
    .instr_clear_o      (instr_clear_o)
  );

  // 10 ns clock
  always #5 clk_i = ~clk_i;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // mtval rule: fetch fault PC, illegal word or halfword, LSU address
  function automatic xlen_t expected_mtval(input mtval_e src, input id_instr_t ins,
                                           input xlen_t addr);
    case (src)
      MT_PC:   return ins.pc;
      MT_WORD: return ins.instr;
      MT_HALF: return {16'h0, ins.instr_c};
      MT_ADDR: return addr;
      default: return '0;
    endcase
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic to_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  task automatic clear_inputs();
    instr_valid_i = 1'b0;
    instr_i       = '0;
    flags_i       = '0;
    load_err_i    = 1'b0;
    store_err_i   = 1'b0;
    lsu_addr_i    = '0;
    stall_i       = 1'b0;
    branch_set_i  = 1'b0;
    jump_set_i    = 1'b0;
    irq_i         = '0;
  endtask

  task automatic add_row(input string name, input kind_e kind, input dec_flags_t flags,
                         input logic [3:0] errs, input irq_in_t irq, input pc_sel_e sel,
                         input logic [5:0] cause, input mtval_e mt, input logic [4:0] ack);
    row_t r;
    r = {kind, flags, errs, irq, sel, cause, mt, ack};
    rows.push_back(r);
    names.push_back(name);
  endtask

  // two ready cycles in a row mean the FSM sits in decode
  task automatic wait_idle();
    int unsigned n;
    int unsigned run;
    n   = 0;
    run = 0;
    while (run < 2 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
      if (id_ready_o === 1'b1 && pc_set_o === 1'b0 && busy_o === 1'b1) begin
        run++;
      end else begin
        run = 0;
      end
    end
    if (run < 2) begin
      abort_run($sformatf("%s: decode stage never became idle", cur_test));
    end
  endtask

  task automatic await_redirect();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (pc_set_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (pc_set_o !== 1'b1) begin
      abort_run($sformatf("%s: no fetch redirect before the timeout", cur_test));
    end
  endtask

  task automatic expect_sleep();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (busy_o !== 1'b0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o !== 1'b0) begin
      abort_run($sformatf("%s: controller never went to sleep", cur_test));
    end
    compare("instr_req asleep", 1'b0, instr_req_o);
  endtask

  // every redirect drops the instruction sitting in decode
  task automatic check_redirect(input row_t r, input xlen_t mtval);
    compare("pc_set", 1'b1, pc_set_o);
    compare("pc_sel", r.sel, pc_sel_o);
    compare("instr_clear", 1'b1, instr_clear_o);
    if (r.sel == PC_MRET) begin
      compare("restore_mret", 1'b1, csr_restore_mret_o);
    end else begin
      compare("cause", r.cause, exc_cause_o);
      compare("mtval", mtval, csr_mtval_o);
      compare("save_cause", 1'b1, csr_save_cause_o);
      compare("save_pc", 1'b1, csr_save_pc_o);
      compare("irq_ack", r.ack[4], irq_ack_o);
      compare("irq_ack_id", r.ack[3:0], irq_ack_id_o);
    end
  endtask

  //////////////////////////////
  // row sequencing
  //////////////////////////////

  task automatic run_row(input int idx);
    row_t      r;
    id_instr_t ins;
    xlen_t     addr;
    r         = rows[idx];
    cur_test  = names[idx];
    rng_state = xorshift(rng_state);
    ins.instr = rng_state;
    rng_state = xorshift(rng_state);
    ins.instr_c = rng_state[15:0];
    rng_state = xorshift(rng_state);
    ins.pc    = {rng_state[31:1], 1'b0};
    ins.is_comp   = r.errs[3];
    ins.fetch_err = r.errs[2];
    rng_state = xorshift(rng_state);
    addr      = rng_state;

    wait_idle();
    to_drive_point();
    case (r.kind)
      ROW_SYNC, ROW_WFI: begin
        instr_valid_i = 1'b1;
        instr_i       = ins;
        flags_i       = r.flags;
        load_err_i    = r.errs[1];
        store_err_i   = r.errs[0];
        lsu_addr_i    = addr;
        @(negedge clk_i);
        compare("early redirect", 1'b0, pc_set_o);
        compare("ready while held", 1'b0, id_ready_o);
        compare("clear while held", 1'b0, instr_clear_o);
        to_drive_point();
        clear_inputs();
        if (r.kind == ROW_SYNC) begin
          // flush cycle follows the decode cycle directly
          @(negedge clk_i);
          check_redirect(r, expected_mtval(r.mtval, ins, addr));
        end else begin
          expect_sleep();
          to_drive_point();
          irq_i = r.irq;
          await_redirect();
          check_redirect(r, '0);
        end
      end
      ROW_IRQ: begin
        irq_i = r.irq;
        await_redirect();
        check_redirect(r, '0);
      end
      ROW_BLOCK: begin
        irq_i = r.irq;
        repeat (WINDOW) begin
          @(negedge clk_i);
          compare("blocked redirect", 1'b0, pc_set_o);
        end
        compare("nmi_mode", 1'b1, nmi_mode_o);
      end
      default: begin
        irq_i   = r.irq;
        stall_i = 1'b1;
        repeat (WINDOW) begin
          @(negedge clk_i);
          compare("ready under stall", 1'b0, id_ready_o);
          compare("clear under stall", 1'b0, instr_clear_o);
          compare("redirect under stall", 1'b0, pc_set_o);
        end
        to_drive_point();
        stall_i = 1'b0;
        await_redirect();
        check_redirect(r, '0);
      end
    endcase
    to_drive_point();
    clear_inputs();
  endtask

  // flags: illegal ecall mret wfi ebreak csr_flush
  // irq lines: mie pending nm meip msip mtip, then the fast vector
  task automatic build_table();
    add_row("illegal_c", ROW_SYNC, 6'b100000, 4'b1000, NO_IRQ, PC_EXC, 6'd2, MT_HALF, 5'h0);
    add_row("illegal_w", ROW_SYNC, 6'b100000, 4'b0000, NO_IRQ, PC_EXC, 6'd2, MT_WORD, 5'h0);
    add_row("ecall", ROW_SYNC, 6'b010000, 4'b0000, NO_IRQ, PC_EXC, 6'd11, MT_ZERO, 5'h0);
    add_row("ebreak", ROW_SYNC, 6'b000010, 4'b0000, NO_IRQ, PC_EXC, 6'd3, MT_ZERO, 5'h0);
    add_row("fetch_fault", ROW_SYNC, 6'b000000, 4'b0100, NO_IRQ, PC_EXC, 6'd1, MT_PC, 5'h0);
    add_row("load_fault", ROW_SYNC, 6'b000000, 4'b0010, NO_IRQ, PC_EXC, 6'd5, MT_ADDR, 5'h0);
    add_row("store_fault", ROW_SYNC, 6'b000000, 4'b0001, NO_IRQ, PC_EXC, 6'd7, MT_ADDR, 5'h0);
    add_row("prio_fetch_ill", ROW_SYNC, 6'b100000, 4'b0100, NO_IRQ, PC_EXC, 6'd1, MT_PC, 5'h0);
    add_row("prio_ebrk_st", ROW_SYNC, 6'b000010, 4'b0001, NO_IRQ, PC_EXC, 6'd3, MT_ZERO, 5'h0);
    add_row("prio_st_ld", ROW_SYNC, 6'b000000, 4'b0011, NO_IRQ, PC_EXC, 6'd7, MT_ADDR, 5'h0);
    add_row("irq_timer", ROW_IRQ, 6'b0, 4'b0, {6'b110001, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd7, MT_ZERO, 5'h0);
    add_row("irq_sw", ROW_IRQ, 6'b0, 4'b0, {6'b110011, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd3, MT_ZERO, 5'h0);
    add_row("irq_ext", ROW_IRQ, 6'b0, 4'b0, {6'b110111, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd11, MT_ZERO, 5'h0);
    // fast lines 3 and 9 pending, 9 wins over the external line
    add_row("irq_fast9", ROW_IRQ, 6'b0, 4'b0, {6'b110100, 15'h0208}, PC_EXC,
            IRQ_FLAG + 6'd16 + 6'd9, MT_ZERO, {1'b1, 4'd9});
    add_row("irq_fast0", ROW_IRQ, 6'b0, 4'b0, {6'b110000, 15'h0001}, PC_EXC,
            IRQ_FLAG + 6'd16, MT_ZERO, {1'b1, 4'd0});
    add_row("nmi", ROW_IRQ, 6'b0, 4'b0, {6'b111100, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd31, MT_ZERO, 5'h0);
    add_row("nmi_blocked", ROW_BLOCK, 6'b0, 4'b0, {6'b001000, 15'h0}, PC_EXC,
            6'd0, MT_ZERO, 5'h0);
    add_row("mret", ROW_SYNC, 6'b001000, 4'b0000, NO_IRQ, PC_MRET, 6'd0, MT_ZERO, 5'h0);
    add_row("nmi_again", ROW_IRQ, 6'b0, 4'b0, {6'b001000, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd31, MT_ZERO, 5'h0);
    add_row("wfi_wake", ROW_WFI, 6'b000100, 4'b0000, {6'b110001, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd7, MT_ZERO, 5'h0);
    add_row("stall_irq", ROW_STALL, 6'b0, 4'b0, {6'b110100, 15'h0}, PC_EXC,
            IRQ_FLAG + 6'd11, MT_ZERO, 5'h0);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    rng_state      = 32'd65;
    cur_test       = "boot";
    clear_inputs();
    build_table();

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare("pc_set in reset", 1'b1, pc_set_o);
    compare("pc_sel in reset", PC_BOOT, pc_sel_o);
    compare("instr_req in reset", 1'b0, instr_req_o);
    compare("id_ready in reset", 1'b0, id_ready_o);
    compare("save_cause in reset", 1'b0, csr_save_cause_o);
    compare("save_pc in reset", 1'b0, csr_save_pc_o);
    compare("restore_mret in reset", 1'b0, csr_restore_mret_o);
    compare("irq_ack in reset", 1'b0, irq_ack_o);

    // boot set lasts one cycle, then first fetch opens the handshake
    to_drive_point();
    fetch_enable_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    compare("pc_set in boot set", 1'b1, pc_set_o);
    compare("pc_sel in boot set", PC_BOOT, pc_sel_o);
    compare("id_ready in boot set", 1'b0, id_ready_o);
    @(negedge clk_i);
    compare("id_ready after boot", 1'b1, id_ready_o);
    compare("pc_set after boot", 1'b0, pc_set_o);
    compare("instr_req after boot", 1'b1, instr_req_o);

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: verilog.f
hw/ctrl_pkg.sv
hw/trap_recorder.sv
hw/irq_arbiter.sv
hw/ctrl_fsm.sv
hw/core_ctrl.sv
sim/tb_core_ctrl.sv
